// ==== Bender.yml ====
package:
  name: mips_trace

sources:
  # Shared package and interface first
  - common/mips_pkg.sv
  - common/retire_if.sv
  # Design blocks
  - fetch/instr_mem.sv
  - execute/alu.sv
  - execute/exec_core.sv
  - trace/trace_port.sv
  - rtl/mips_trace_top.sv
  # Testbench with bound assertions
  - target: test
    files:
      - testbench/mips_trace_props.sv
      - testbench/tb_mips_trace.sv

// ==== common/mips_pkg.sv ====
package mips_pkg;

    //////////////////////////////////////////////////////////////////////
    // Basic widths
    //////////////////////////////////////////////////////////////////////

    // Data, instruction and PC word
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] reg_idx_t;

    // Primary opcode and R-type function field
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    //////////////////////////////////////////////////////////////////////
    // Enumerations
    //////////////////////////////////////////////////////////////////////

    // Operations understood by the ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_PASS_B
    } alu_op_t;

    // Sequential core FSM
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        EXEC,
        HALTED
    } core_state_t;

    //////////////////////////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////////////////////////

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;

    // R-type function codes
    localparam funct_t F_SLL  = 6'b000000;
    localparam funct_t F_ADD  = 6'b100000;
    localparam funct_t F_SUB  = 6'b100010;
    localparam funct_t F_SUBU = 6'b100011;
    localparam funct_t F_AND  = 6'b100100;
    localparam funct_t F_OR   = 6'b100101;
    localparam funct_t F_XOR  = 6'b100110;
    localparam funct_t F_NOR  = 6'b100111;
    localparam funct_t F_SLT  = 6'b101010;

    // Stops the core, retires no record
    localparam word_t HALT_WORD = 32'hffff_ffff;

endpackage

// ==== common/retire_if.sv ====
`timescale 1ns/10ps

// One retired-instruction record from core to trace port,
// with the credit flag coming back the other way
interface retire_if
    import mips_pkg::*;
();

    // Record moves in every cycle with rec_valid high
    logic     rec_valid;
    word_t    rec_pc;
    reg_idx_t rec_dest;
    word_t    rec_value;

    // At least one credit left in the trace port
    logic     has_credit;

    modport core (
        output rec_valid,
        output rec_pc,
        output rec_dest,
        output rec_value,
        input  has_credit
    );

    modport trace (
        input  rec_valid,
        input  rec_pc,
        input  rec_dest,
        input  rec_value,
        output has_credit
    );

endinterface

// ==== execute/alu.sv ====
`timescale 1ns/10ps

module alu
    import mips_pkg::*;
(
    input  alu_op_t    op,
    input  word_t      a,
    input  word_t      b,
    input  logic [4:0] shamt,
    output word_t      y,
    output logic       zero
);

    always_comb
    begin
        case (op)
            // ADD wraps the same way SUBU does
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_NOR:    y = ~(a | b);
            ALU_XOR:    y = a ^ b;
            // Signed compare, result is 0 or 1
            ALU_SLT:    y = {31'b0, ($signed(a) < $signed(b))};
            // Shift of b, a is ignored
            ALU_SLL:    y = b << shamt;
            ALU_PASS_B: y = b;
            default:    y = b;
        endcase
    end

    // BEQ tests this after a subtract
    assign zero = (y == '0);

endmodule

// ==== execute/exec_core.sv ====
`timescale 1ns/10ps

module exec_core
    import mips_pkg::*;
#(
    parameter  int DMEM_WORDS = 16,
    localparam int DMEM_AW    = $clog2(DMEM_WORDS)
)
(
    input  logic   i_clk,
    input  logic   reset,
    input  logic   start,
    output logic   halted,
    output word_t  fetch_pc,
    input  word_t  instr,
    retire_if.core ret
);

    core_state_t state;
    word_t       pc;
    word_t       regs [32];
    word_t       dmem [DMEM_WORDS];

    // Instruction fields
    opcode_t     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [4:0]  shamt;
    funct_t      funct;
    logic [15:0] imm;
    logic [25:0] target;

    // Decode results
    alu_op_t     alu_op;
    logic        use_imm;
    logic        use_zext;
    logic        wr_en;
    reg_idx_t    wr_idx;
    logic        is_lw;
    logic        is_sw;
    logic        is_beq;
    logic        is_j;
    logic        is_halt;

    // Datapath
    word_t             imm_sext;
    word_t             imm_zext;
    word_t             rs_val;
    word_t             rt_val;
    word_t             alu_b;
    word_t             alu_y;
    logic              alu_zero;
    word_t             load_data;
    word_t             wr_data;
    word_t             pc_plus4;
    word_t             br_target;
    word_t             next_pc;
    logic [DMEM_AW-1:0] dmem_idx;
    logic              fire;

    //////////////////////////////////////////////////////////////////////
    // Field split and decode
    //////////////////////////////////////////////////////////////////////

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];
    assign target = instr[25:0];

    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'b0, imm};

    always_comb
    begin
        alu_op   = ALU_PASS_B;
        use_imm  = 1'b0;
        use_zext = 1'b0;
        wr_en    = 1'b0;
        wr_idx   = rt;
        is_lw    = 1'b0;
        is_sw    = 1'b0;
        is_beq   = 1'b0;
        is_j     = 1'b0;
        is_halt  = (instr == HALT_WORD);
        if (!is_halt)
        begin
            case (opcode)
                OP_RTYPE:
                begin
                    wr_idx = rd;
                    wr_en  = 1'b1;
                    case (funct)
                        F_ADD:   alu_op = ALU_ADD;
                        F_SUB:   alu_op = ALU_SUB;
                        F_SUBU:  alu_op = ALU_SUB;
                        F_AND:   alu_op = ALU_AND;
                        F_OR:    alu_op = ALU_OR;
                        F_NOR:   alu_op = ALU_NOR;
                        F_XOR:   alu_op = ALU_XOR;
                        F_SLT:   alu_op = ALU_SLT;
                        F_SLL:   alu_op = ALU_SLL;
                        // Unknown function retires like a no-op
                        default: wr_en  = 1'b0;
                    endcase
                end
                OP_ADDI:
                begin
                    alu_op  = ALU_ADD;
                    use_imm = 1'b1;
                    wr_en   = 1'b1;
                end
                OP_ORI:
                begin
                    alu_op   = ALU_OR;
                    use_imm  = 1'b1;
                    use_zext = 1'b1;
                    wr_en    = 1'b1;
                end
                OP_SLTI:
                begin
                    alu_op  = ALU_SLT;
                    use_imm = 1'b1;
                    wr_en   = 1'b1;
                end
                OP_LW:
                begin
                    alu_op  = ALU_ADD;
                    use_imm = 1'b1;
                    wr_en   = 1'b1;
                    is_lw   = 1'b1;
                end
                OP_SW:
                begin
                    alu_op  = ALU_ADD;
                    use_imm = 1'b1;
                    is_sw   = 1'b1;
                end
                OP_BEQ:
                begin
                    alu_op = ALU_SUB;
                    is_beq = 1'b1;
                end
                OP_J:    is_j = 1'b1;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operands, ALU and memory
    //////////////////////////////////////////////////////////////////////

    // r0 always reads as zero
    assign rs_val = (rs == '0) ? '0 : regs[rs];
    assign rt_val = (rt == '0) ? '0 : regs[rt];

    assign alu_b = use_imm ? (use_zext ? imm_zext : imm_sext) : rt_val;

    alu u_alu (
        .op    (alu_op),
        .a     (rs_val),
        .b     (alu_b),
        .shamt (shamt),
        .y     (alu_y),
        .zero  (alu_zero)
    );

    // Word address wraps modulo DMEM_WORDS
    assign dmem_idx  = alu_y[DMEM_AW+1:2];
    assign load_data = dmem[dmem_idx];
    assign wr_data   = is_lw ? load_data : alu_y;

    // Next PC selection
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb
    begin
        next_pc = pc_plus4;
        if (is_beq && alu_zero)
        begin
            next_pc = br_target;
        end
        else if (is_j)
        begin
            next_pc = {pc_plus4[31:28], target, 2'b00};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Retire record
    //////////////////////////////////////////////////////////////////////

    // Completes only with a credit in hand, HALT never retires
    assign fire = (state == EXEC) && !is_halt && ret.has_credit;

    assign ret.rec_valid = fire;
    assign ret.rec_pc    = pc;
    // Writes aimed at r0 report no destination
    assign ret.rec_dest  = (wr_en && (wr_idx != '0)) ? wr_idx : '0;
    assign ret.rec_value = wr_en ? wr_data : (is_sw ? rt_val : next_pc);

    assign fetch_pc = pc;
    assign halted   = (state == HALTED);

    //////////////////////////////////////////////////////////////////////
    // FSM, register file and data memory
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            pc    <= '0;
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else
        begin
            case (state)
                IDLE, HALTED:
                begin
                    // Restart keeps registers and data memory
                    if (start)
                    begin
                        pc    <= '0;
                        state <= FETCH;
                    end
                end
                // Memory read happens on this edge
                FETCH: state <= EXEC;
                EXEC:
                begin
                    if (is_halt)
                    begin
                        state <= HALTED;
                    end
                    else if (fire)
                    begin
                        if (wr_en && (wr_idx != '0))
                        begin
                            regs[wr_idx] <= wr_data;
                        end
                        if (is_sw)
                        begin
                            dmem[dmem_idx] <= rt_val;
                        end
                        pc    <= next_pc;
                        state <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== fetch/instr_mem.sv ====
`timescale 1ns/10ps

module instr_mem
    import mips_pkg::*;
#(
    parameter  int IMEM_WORDS = 64,
    localparam int IMEM_AW    = $clog2(IMEM_WORDS)
)
(
    input  logic               i_clk,
    input  logic               reset,
    input  word_t              fetch_pc,
    output word_t              instr,
    input  logic               imem_we,
    input  logic [IMEM_AW-1:0] imem_addr,
    input  word_t              imem_wdata
);

    // Program storage, one word per entry
    word_t mem [IMEM_WORDS];

    // Load port, one word per cycle
    always_ff @(posedge i_clk)
    begin
        if (imem_we)
        begin
            mem[imem_addr] <= imem_wdata;
        end
    end

    // Synchronous read, byte PC with the two low bits dropped
    always_ff @(posedge i_clk)
    begin
        if (reset)
        begin
            instr <= '0;
        end
        else
        begin
            instr <= mem[fetch_pc[IMEM_AW+1:2]];
        end
    end

endmodule

// ==== flist.f ====
common/mips_pkg.sv
common/retire_if.sv
fetch/instr_mem.sv
execute/alu.sv
execute/exec_core.sv
trace/trace_port.sv
rtl/mips_trace_top.sv
testbench/mips_trace_props.sv
testbench/tb_mips_trace.sv

// ==== rtl/mips_trace_top.sv ====
`timescale 1ns/10ps

module mips_trace_top
    import mips_pkg::*;
#(
    parameter int IMEM_WORDS    = 64,
    parameter int DMEM_WORDS    = 16,
    parameter int TRACE_CREDITS = 4
)
(
    input  logic                          i_clk,
    input  logic                          reset,
    // Program load port, word index
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  word_t                         imem_wdata,
    // Run control
    input  logic                          start,
    output logic                          halted,
    // Retire trace
    output logic                          trace_valid,
    output word_t                         trace_pc,
    output reg_idx_t                      trace_dest,
    output word_t                         trace_value,
    input  logic                          trace_credit
);

    word_t fetch_pc;
    word_t instr;

    // Retire records from core to trace port
    retire_if u_ret ();

    instr_mem #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_imem (
        .i_clk      (i_clk),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .instr      (instr),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata)
    );

    exec_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_core (
        .i_clk    (i_clk),
        .reset    (reset),
        .start    (start),
        .halted   (halted),
        .fetch_pc (fetch_pc),
        .instr    (instr),
        .ret      (u_ret.core)
    );

    trace_port #(
        .TRACE_CREDITS (TRACE_CREDITS)
    ) u_trace (
        .i_clk        (i_clk),
        .reset        (reset),
        .ret          (u_ret.trace),
        .trace_credit (trace_credit),
        .trace_valid  (trace_valid),
        .trace_pc     (trace_pc),
        .trace_dest   (trace_dest),
        .trace_value  (trace_value)
    );

endmodule

// ==== testbench/mips_trace_props.sv ====
`timescale 1ns/10ps

// Checks on the credit interface of the trace port
module mips_trace_props
#(
    parameter  int TRACE_CREDITS = 4,
    localparam int CW            = $clog2(TRACE_CREDITS + 1)
)
(
    input logic          i_clk,
    input logic          reset,
    input logic          rec_valid,
    input logic          has_credit,
    input logic [CW-1:0] credit_cnt,
    input logic          trace_valid
);

    // Number of failed assertions
    int fail_count = 0;

    // A record only moves with a credit in hand
    no_record_without_credit: assert property (
        @(posedge i_clk) disable iff (reset)
        rec_valid |-> has_credit
    )
    else
    begin
        fail_count++;
        $error("record sent while has_credit is low");
    end

    // Returns never push the count past its start value
    credit_count_bound: assert property (
        @(posedge i_clk) disable iff (reset)
        credit_cnt <= TRACE_CREDITS
    )
    else
    begin
        fail_count++;
        $error("credit count above TRACE_CREDITS");
    end

    // Output register is cleared by reset
    valid_low_after_reset: assert property (
        @(posedge i_clk)
        reset |=> !trace_valid
    )
    else
    begin
        fail_count++;
        $error("trace_valid high in the cycle after reset");
    end

endmodule

bind trace_port mips_trace_props #(
    .TRACE_CREDITS (TRACE_CREDITS)
) u_props (
    .i_clk       (i_clk),
    .reset       (reset),
    .rec_valid   (ret.rec_valid),
    .has_credit  (ret.has_credit),
    .credit_cnt  (credit_cnt),
    .trace_valid (trace_valid)
);

// ==== testbench/tb_mips_trace.sv ====
`timescale 1ns/10ps

module tb_mips_trace
    import mips_pkg::*;
();

    localparam int IMEM_WORDS      = 64;
    localparam int IMEM_AW         = $clog2(IMEM_WORDS);
    localparam int DMEM_WORDS      = 16;
    localparam int TRACE_CREDITS   = 4;
    localparam int NUM_PROGS       = 20;
    localparam int MAX_INSTR       = 48;
    localparam int MAX_DELAY       = 8;
    localparam int CLK_PERIOD      = 20;
    // Generous per-instruction budget, loading and credit waits included
    localparam int WATCHDOG_CYCLES = NUM_PROGS * (MAX_INSTR + 1) * 12;

    // DUT ports
    logic               i_clk;
    logic               reset;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    word_t              imem_wdata;
    logic               start;
    logic               halted;
    logic               trace_valid;
    word_t              trace_pc;
    reg_idx_t           trace_dest;
    word_t              trace_value;
    logic               trace_credit = 1'b0;

    // Random source
    logic [31:0] rng = 32'hed47dee1;

    // Current program and architectural model state
    word_t prog [IMEM_WORDS];
    int    prog_len;
    word_t m_regs [32];
    word_t m_dmem [DMEM_WORDS];

    // Expected records in retire order
    word_t    exp_pc_q [$];
    reg_idx_t exp_dest_q [$];
    word_t    exp_value_q [$];

    // Cycles at which credits go back to the DUT
    int due_q [$];

    int   cyc = 0;
    int   start_cyc = 0;
    logic first_pending = 1'b0;
    int   outstanding = 0;
    int   checks = 0;
    int   errors = 0;
    int   assert_fails = 0;

    mips_trace_top #(
        .IMEM_WORDS    (IMEM_WORDS),
        .DMEM_WORDS    (DMEM_WORDS),
        .TRACE_CREDITS (TRACE_CREDITS)
    ) u_dut (
        .i_clk        (i_clk),
        .reset        (reset),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .start        (start),
        .halted       (halted),
        .trace_valid  (trace_valid),
        .trace_pc     (trace_pc),
        .trace_dest   (trace_dest),
        .trace_value  (trace_value),
        .trace_credit (trace_credit)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // 32-bit xorshift
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One random instruction at word index idx of a len-word body
    function automatic word_t make_instr(input int idx, input int len);
        word_t    r;
        int       kind;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        funct_t   fn;
        word_t    instr;
        r     = next_random();
        kind  = r % 17;
        // Only r0..r7, so values get reused often
        rs    = reg_idx_t'(r[10:8]);
        rt    = reg_idx_t'(r[13:11]);
        rd    = reg_idx_t'(r[16:14]);
        r     = next_random();
        fn    = F_ADD;
        instr = '0;
        case (kind)
            1:       fn = F_SUB;
            2:       fn = F_SUBU;
            3:       fn = F_AND;
            4:       fn = F_OR;
            5:       fn = F_NOR;
            6:       fn = F_XOR;
            7:       fn = F_SLT;
            8:       fn = F_SLL;
            default: fn = F_ADD;
        endcase
        case (kind)
            0, 1, 2, 3, 4, 5, 6, 7, 8:
                instr = {OP_RTYPE, rs, rt, rd, r[4:0], fn};
            9:  instr = {OP_ADDI, rs, rt, r[15:0]};
            10: instr = {OP_ORI, rs, rt, r[15:0]};
            11: instr = {OP_SLTI, rs, rt, r[15:0]};
            // Base r0 half the time so stores and loads hit the same words
            12: instr = {OP_LW, r[16] ? 5'd0 : rs, rt, {10{r[5]}}, r[3:0], 2'b00};
            13: instr = {OP_SW, r[16] ? 5'd0 : rs, rt, {10{r[5]}}, r[3:0], 2'b00};
            // Forward targets only, at most up to the HALT word
            14: instr = {OP_BEQ, rs, r[17] ? rs : rt, 16'(r % (len - idx))};
            15: instr = {OP_J, 26'(idx + 1 + (r % (len - idx)))};
            // Opcode the core does not know
            default: instr = {6'b110011, r[25:0]};
        endcase
        return instr;
    endfunction

    task automatic build_program();
        prog_len = 1 + (next_random() % MAX_INSTR);
        for (int i = 0; i < prog_len; i++)
        begin
            prog[i] = make_instr(i, prog_len);
        end
        prog[prog_len] = HALT_WORD;
    endtask

    // Architectural model, queues one record per retired instruction
    task automatic run_model();
        word_t    pc;
        word_t    npc;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    v;
        word_t    sext;
        word_t    addr;
        reg_idx_t dst;
        logic     wr;
        int       idx;
        pc  = '0;
        ins = prog[0];
        while (ins != HALT_WORD)
        begin
            a    = m_regs[ins[25:21]];
            b    = m_regs[ins[20:16]];
            sext = {{16{ins[15]}}, ins[15:0]};
            addr = a + sext;
            idx  = (addr >> 2) % DMEM_WORDS;
            npc  = pc + 32'd4;
            dst  = ins[20:16];
            wr   = 1'b1;
            v    = '0;
            case (ins[31:26])
                OP_RTYPE:
                begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        F_ADD:         v = a + b;
                        F_SUB, F_SUBU: v = a - b;
                        F_AND:         v = a & b;
                        F_OR:          v = a | b;
                        F_NOR:         v = ~(a | b);
                        F_XOR:         v = a ^ b;
                        F_SLT:         v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F_SLL:         v = b << ins[10:6];
                        default:       wr = 1'b0;
                    endcase
                end
                OP_ADDI: v = addr;
                OP_ORI:  v = a | {16'b0, ins[15:0]};
                OP_SLTI: v = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                OP_LW:   v = m_dmem[idx];
                OP_SW:
                begin
                    wr          = 1'b0;
                    m_dmem[idx] = b;
                end
                OP_BEQ:
                begin
                    wr = 1'b0;
                    if (a == b)
                    begin
                        npc = npc + {sext[29:0], 2'b00};
                    end
                end
                OP_J:
                begin
                    wr  = 1'b0;
                    npc = {npc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            // Written value, stored data, or next PC
            if (wr)
            begin
                if (dst != '0)
                begin
                    m_regs[dst] = v;
                end
            end
            else
            begin
                dst = '0;
                v   = (ins[31:26] == OP_SW) ? b : npc;
            end
            exp_pc_q.push_back(pc);
            exp_dest_q.push_back(dst);
            exp_value_q.push_back(v);
            pc  = npc;
            ins = prog[pc >> 2];
        end
    endtask

    // Reset also wipes the model's registers and data memory
    task automatic apply_reset();
        reset <= 1'b1;
        repeat (10) @(posedge i_clk);
        reset <= 1'b0;
        for (int i = 0; i < 32; i++)
        begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++)
        begin
            m_dmem[i] = '0;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i <= prog_len; i++)
        begin
            imem_we    <= 1'b1;
            imem_addr  <= IMEM_AW'(i);
            imem_wdata <= prog[i];
            @(posedge i_clk);
        end
        imem_we <= 1'b0;
    endtask

    task automatic run_program();
        start <= 1'b1;
        @(posedge i_clk);
        start <= 1'b0;
        @(posedge i_clk);
        while (!halted)
        begin
            @(posedge i_clk);
        end
        // Nothing should be pending, HALT has no record
        check_equal(exp_pc_q.size(), 0, "records missing at halt");
        repeat (4) @(posedge i_clk);
        // Let every credit go home before the next start
        while (due_q.size() != 0)
        begin
            @(posedge i_clk);
        end
        repeat (2) @(posedge i_clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Trace monitor and credit return
    //////////////////////////////////////////////////////////////////////

    always @(posedge i_clk)
    begin : monitor
        int due;
        cyc++;
        if (start)
        begin
            start_cyc     = cyc;
            first_pending = 1'b1;
        end
        if (trace_valid)
        begin
            if (first_pending)
            begin
                check_equal(cyc - start_cyc, 3, "cycles from start to first record");
                first_pending = 1'b0;
            end
            if (exp_pc_q.size() == 0)
            begin
                errors++;
                $display("Unexpected trace record from pc %h at %0t", trace_pc, $time);
            end
            else
            begin
                check_equal(trace_pc, exp_pc_q.pop_front(), "trace_pc");
                check_equal(trace_dest, exp_dest_q.pop_front(), "trace_dest");
                check_equal(trace_value, exp_value_q.pop_front(), "trace_value");
            end
            outstanding++;
            check_equal(outstanding <= TRACE_CREDITS, 1, "outstanding within credits");
            due = cyc + (next_random() % (MAX_DELAY + 1));
            // One credit per cycle, kept in order
            if ((due_q.size() != 0) && (due <= due_q[$]))
            begin
                due = due_q[$] + 1;
            end
            due_q.push_back(due);
        end
        if ((due_q.size() != 0) && (due_q[0] <= cyc))
        begin
            void'(due_q.pop_front());
            outstanding--;
            trace_credit <= 1'b1;
        end
        else
        begin
            trace_credit <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        start      = 1'b0;
        for (int p = 0; p < NUM_PROGS; p++)
        begin
            // Some runs restart without reset, state carries over
            if ((p % 7) == 0)
            begin
                apply_reset();
                @(posedge i_clk);
                check_equal(halted, 0, "halted after reset");
                check_equal(trace_valid, 0, "trace_valid after reset");
            end
            build_program();
            run_model();
            load_program();
            run_program();
        end
        assert_fails = u_dut.u_trace.u_props.fail_count;
        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0))
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Timeout, run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== trace/trace_port.sv ====
`timescale 1ns/10ps

module trace_port
    import mips_pkg::*;
#(
    parameter  int TRACE_CREDITS = 4,
    localparam int CW            = $clog2(TRACE_CREDITS + 1)
)
(
    input  logic     i_clk,
    input  logic     reset,
    retire_if.trace  ret,
    input  logic     trace_credit,
    output logic     trace_valid,
    output word_t    trace_pc,
    output reg_idx_t trace_dest,
    output word_t    trace_value
);

    // Records the receiver can still take
    logic [CW-1:0] credit_cnt;

    //////////////////////////////////////////////////////////////////////
    // Credit counter
    //////////////////////////////////////////////////////////////////////

    // Spend and return in one cycle cancel out
    always_ff @(posedge i_clk)
    begin
        if (reset)
        begin
            credit_cnt <= CW'(TRACE_CREDITS);
        end
        else
        begin
            case ({ret.rec_valid, trace_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    assign ret.has_credit = (credit_cnt != '0);

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    // Valid is one cycle behind rec_valid
    always_ff @(posedge i_clk)
    begin
        if (reset)
        begin
            trace_valid <= 1'b0;
        end
        else
        begin
            trace_valid <= ret.rec_valid;
        end
    end

    // Payload only loads with a record
    always_ff @(posedge i_clk)
    begin
        if (ret.rec_valid)
        begin
            trace_pc    <= ret.rec_pc;
            trace_dest  <= ret.rec_dest;
            trace_value <= ret.rec_value;
        end
    end

endmodule
